/* source/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and register file sizes
`define CPU_XLEN 32
`define CPU_NREGS 32
`define CPU_REG_BITS 5
`define CPU_SHAMT_BITS 5

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_ADDIU 6'h09
`define OP_SLTI 6'h0a
`define OP_ANDI 6'h0c
`define OP_ORI 6'h0d
`define OP_XORI 6'h0e
`define OP_LUI 6'h0f

// r-type funct codes, instr[5:0]
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_XOR 6'h26
`define FN_NOR 6'h27
`define FN_SLT 6'h2a
`define FN_SLTU 6'h2b

`endif

/* source/cpuPkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpuPkg;

	// operation selected by the decoder, consumed by the execute stage
	// ALU_NONE marks an encoding that was not recognized
	typedef enum logic [4:0] {
		ALU_NONE,
		// r-type register/register ops
		ALU_ADDU,
		ALU_SUBU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		// shifts act on rt by the shamt field
		ALU_SLL,
		ALU_SRL,
		// i-type, opB already holds the extended immediate
		ALU_ADDIU,
		ALU_ANDI,
		ALU_ORI,
		ALU_XORI,
		ALU_SLTI,
		// load upper immediate, opB is the zero-extended imm
		ALU_LUI
	} aluOp_t;

	// one decoded operation on its way to execute
	typedef struct packed {
		// what to compute
		aluOp_t op;
		// destination register, rd for r-type and rt for i-type
		logic [`CPU_REG_BITS-1:0] dest;
		// rs value
		logic [`CPU_XLEN-1:0] opA;
		// rt value or extended immediate
		logic [`CPU_XLEN-1:0] opB;
		// shift distance for sll/srl
		logic [`CPU_SHAMT_BITS-1:0] shamt;
	} issue_t;

endpackage

`default_nettype wire

/* source/regReadIf.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

// two asynchronous read ports between decoder and register file
interface regReadIf;

	// register indices, driven by the decoder
	logic [`CPU_REG_BITS-1:0] readReg1;
	logic [`CPU_REG_BITS-1:0] readReg2;

	// read values, combinational from the indices
	logic [`CPU_XLEN-1:0] readData1;
	logic [`CPU_XLEN-1:0] readData2;

	modport decoder (
		output readReg1,
		output readReg2,
		input readData1,
		input readData2
	);

	modport regfile (
		input readReg1,
		input readReg2,
		output readData1,
		output readData2
	);

endinterface

`default_nettype wire

/* source/issueIf.sv */
`timescale 1ns/10ps
`default_nettype none

// decoded operation from the decoder to the execute stage
// no handshake, execute takes every valid cycle
interface issueIf;

	import cpuPkg::*;

	// high for one cycle per legal instruction
	logic valid;

	// operands are already resolved, including bypass
	issue_t payload;

	modport producer (
		output valid,
		output payload
	);

	// execute only samples
	modport consumer (
		input valid,
		input payload
	);

endinterface

`default_nettype wire

/* source/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module instrDecoder (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [31:0] instr,
	output logic illegalInstr,
	regReadIf.decoder regRd,
	issueIf.producer issue
);

	import cpuPkg::*;

	// instruction register
	logic instrValidQ;
	logic [31:0] instrQ;

	// instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [`CPU_REG_BITS-1:0] rs;
	logic [`CPU_REG_BITS-1:0] rt;
	logic [`CPU_REG_BITS-1:0] rd;
	logic [`CPU_SHAMT_BITS-1:0] shamt;
	logic [15:0] imm;

	// decode results
	aluOp_t op;
	logic immSigned;
	logic isRtype;
	logic [`CPU_XLEN-1:0] immExt;

	// capture stage, valid is the only control bit
	always_ff @(posedge clk) begin
		if (reset) begin
			instrValidQ <= 1'b0;
		end else begin
			instrValidQ <= instrValid;
		end
	end

	// payload only moves when a new word arrives
	always_ff @(posedge clk) begin
		if (instrValid) begin
			instrQ <= instr;
		end
	end

	assign opcode = instrQ[31:26];
	assign rs = instrQ[25:21];
	assign rt = instrQ[20:16];
	assign rd = instrQ[15:11];
	assign shamt = instrQ[10:6];
	assign funct = instrQ[5:0];
	assign imm = instrQ[15:0];
	assign isRtype = (opcode == `OP_RTYPE);

	// opcode/funct to operation
	// only addiu and slti sign-extend their immediate
	always_comb begin
		op = ALU_NONE;
		immSigned = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				case (funct)
					`FN_ADDU: op = ALU_ADDU;
					`FN_SUBU: op = ALU_SUBU;
					`FN_AND: op = ALU_AND;
					`FN_OR: op = ALU_OR;
					`FN_XOR: op = ALU_XOR;
					`FN_NOR: op = ALU_NOR;
					`FN_SLT: op = ALU_SLT;
					`FN_SLTU: op = ALU_SLTU;
					`FN_SLL: op = ALU_SLL;
					`FN_SRL: op = ALU_SRL;
					default: op = ALU_NONE;
				endcase
			end
			`OP_ADDIU: begin
				op = ALU_ADDIU;
				immSigned = 1'b1;
			end
			`OP_SLTI: begin
				op = ALU_SLTI;
				immSigned = 1'b1;
			end
			`OP_ANDI: op = ALU_ANDI;
			`OP_ORI: op = ALU_ORI;
			`OP_XORI: op = ALU_XORI;
			`OP_LUI: op = ALU_LUI;
			default: op = ALU_NONE;
		endcase
	end

	assign immExt = immSigned ? {{(`CPU_XLEN-16){imm[15]}}, imm} : {{(`CPU_XLEN-16){1'b0}}, imm};

	// both ports always read rs and rt
	assign regRd.readReg1 = rs;
	assign regRd.readReg2 = rt;

	// unknown encoding, one cycle pulse and nothing issued
	assign illegalInstr = instrValidQ && (op == ALU_NONE);
	assign issue.valid = instrValidQ && (op != ALU_NONE);

	always_comb begin
		issue.payload.op = op;
		issue.payload.dest = isRtype ? rd : rt;
		issue.payload.opA = regRd.readData1;
		// i-type replaces rt with the immediate
		issue.payload.opB = isRtype ? regRd.readData2 : immExt;
		issue.payload.shamt = shamt;
	end

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module regFile (
	input logic clk,
	input logic reset,
	regReadIf.regfile rd,
	input logic regWrite,
	input logic [`CPU_REG_BITS-1:0] writeReg,
	input logic [`CPU_XLEN-1:0] writeData
);

	// general purpose registers
	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	// a write that will actually land
	logic writeActive;

	// register 0 is never stored
	assign writeActive = regWrite && (writeReg != '0);

	// write lands at the end of the writeback cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeActive) begin
			regs[writeReg] <= writeData;
		end
	end

	// port 1
	// zero register first, then write-through from the pending write
	always_comb begin
		if (rd.readReg1 == '0) begin
			rd.readData1 = '0;
		end else if (writeActive && (writeReg == rd.readReg1)) begin
			rd.readData1 = writeData;
		end else begin
			rd.readData1 = regs[rd.readReg1];
		end
	end

	// port 2, same priority as port 1
	always_comb begin
		if (rd.readReg2 == '0) begin
			rd.readData2 = '0;
		end else if (writeActive && (writeReg == rd.readReg2)) begin
			rd.readData2 = writeData;
		end else begin
			rd.readData2 = regs[rd.readReg2];
		end
	end

endmodule

`default_nettype wire

/* source/aluExecute.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module aluExecute (
	input logic clk,
	input logic reset,
	issueIf.consumer issue,
	output logic regWrite,
	output logic [`CPU_REG_BITS-1:0] writeReg,
	output logic [`CPU_XLEN-1:0] writeData,
	output logic wbValid,
	output logic [`CPU_REG_BITS-1:0] wbReg,
	output logic [`CPU_XLEN-1:0] wbData
);

	import cpuPkg::*;

	// input register of the stage
	logic validQ;
	issue_t issueQ;

	logic [`CPU_XLEN-1:0] result;

	always_ff @(posedge clk) begin
		if (reset) begin
			validQ <= 1'b0;
		end else begin
			validQ <= issue.valid;
		end
	end

	// operands held only when something is issued
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			issueQ <= issue.payload;
		end
	end

	// result is combinational from the input register
	always_comb begin
		case (issueQ.op)
			ALU_ADDU,
			ALU_ADDIU: result = issueQ.opA + issueQ.opB;
			ALU_SUBU: result = issueQ.opA - issueQ.opB;
			ALU_AND,
			ALU_ANDI: result = issueQ.opA & issueQ.opB;
			ALU_OR,
			ALU_ORI: result = issueQ.opA | issueQ.opB;
			ALU_XOR,
			ALU_XORI: result = issueQ.opA ^ issueQ.opB;
			ALU_NOR: result = ~(issueQ.opA | issueQ.opB);
			// signed compare, immediate already sign-extended for slti
			ALU_SLT,
			ALU_SLTI: begin
				result = '0;
				result[0] = $signed(issueQ.opA) < $signed(issueQ.opB);
			end
			ALU_SLTU: begin
				result = '0;
				result[0] = issueQ.opA < issueQ.opB;
			end
			// shifts take rt, which sits in opB
			ALU_SLL: result = issueQ.opB << issueQ.shamt;
			ALU_SRL: result = issueQ.opB >> issueQ.shamt;
			// zero-extended imm moved to the upper half
			ALU_LUI: result = issueQ.opB << 16;
			default: result = '0;
		endcase
	end

	// write enable stays high for dest 0, regFile drops it
	assign regWrite = validQ;
	assign writeReg = issueQ.dest;
	assign writeData = result;

	// writeback port mirrors the register write
	assign wbValid = regWrite;
	assign wbReg = writeReg;
	assign wbData = writeData;

endmodule

`default_nettype wire

/* source/execCore.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module execCore (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [31:0] instr,
	output logic illegalInstr,
	output logic wbValid,
	output logic [`CPU_REG_BITS-1:0] wbReg,
	output logic [`CPU_XLEN-1:0] wbData
);

	// register write port, execute to register file
	logic regWrite;
	logic [`CPU_REG_BITS-1:0] writeReg;
	logic [`CPU_XLEN-1:0] writeData;

	regReadIf regReadBus ();
	issueIf issueBus ();

	// capture, decode and operand read
	instrDecoder u_instrDecoder (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.illegalInstr(illegalInstr),
		.regRd(regReadBus.decoder),
		.issue(issueBus.producer)
	);

	// storage with write-through to the decoder's reads
	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.rd(regReadBus.regfile),
		.regWrite(regWrite),
		.writeReg(writeReg),
		.writeData(writeData)
	);

	// compute and write back
	aluExecute u_aluExecute (
		.clk(clk),
		.reset(reset),
		.issue(issueBus.consumer),
		.regWrite(regWrite),
		.writeReg(writeReg),
		.writeData(writeData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

/* testbench/execCore_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module execCore_assertions (
	input logic clk,
	input logic reset,
	input logic illegalInstr,
	input logic wbValid,
	input logic [`CPU_REG_BITS-1:0] readReg1,
	input logic [`CPU_REG_BITS-1:0] readReg2,
	input logic [`CPU_XLEN-1:0] readData1,
	input logic [`CPU_XLEN-1:0] readData2
);

	// execute stage is empty once a reset edge has passed
	wbIdleInReset: assert property (@(posedge clk) reset |=> !wbValid)
		else $error("wbValid high while reset is applied");

	// the slot after an illegal pulse belongs to that instruction
	noWbForIllegal: assert property (@(posedge clk) disable iff (reset)
		illegalInstr |=> !wbValid)
		else $error("writeback produced for an illegal instruction");

	// register 0 on both read ports
	zeroRegPort1: assert property (@(posedge clk) disable iff (reset)
		(readReg1 == '0) |-> (readData1 == '0))
		else $error("read port 1 returned nonzero for register 0");

	zeroRegPort2: assert property (@(posedge clk) disable iff (reset)
		(readReg2 == '0) |-> (readData2 == '0))
		else $error("read port 2 returned nonzero for register 0");

endmodule

bind execCore execCore_assertions u_execCoreAssertions (
	.clk(clk),
	.reset(reset),
	.illegalInstr(illegalInstr),
	.wbValid(wbValid),
	.readReg1(regReadBus.readReg1),
	.readReg2(regReadBus.readReg2),
	.readData1(regReadBus.readData1),
	.readData2(regReadBus.readData2)
);

`default_nettype wire

/* testbench/execCore_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module execCore_tb;

	logic clk = 1'b0;
	logic reset;
	logic instrValid;
	logic [31:0] instr;
	logic illegalInstr;
	logic wbValid;
	logic [4:0] wbReg;
	logic [31:0] wbData;

	// reference registers written in issue order
	logic [31:0] modelRegs [32];
	logic [31:0] rngState;
	int edgeCount = 0;

	// expected events tagged with the edge count at which they show
	int wbEdgeQ [$];
	// {reg, data}
	logic [36:0] wbExpQ [$];
	int illEdgeQ [$];
	logic expectWb;
	logic expectIll;

	execCore u_execCore (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.illegalInstr(illegalInstr),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		edgeCount <= edgeCount + 1;
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s is %h, expected %h",
				$time, what, actual, expected);
			$display("Testbench failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// mostly r0..r7 so that neighbours depend on each other
	function automatic logic [4:0] pickReg();
		logic [31:0] r;
		r = nextRandom();
		if (r[7:5] != 3'd0) begin
			return {2'b00, r[2:0]};
		end
		return r[4:0];
	endfunction

	function automatic logic [31:0] encodeRtype(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {`OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] encodeItype(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] randomInstr();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [31:0] r;
		rs = pickReg();
		rt = pickReg();
		rd = pickReg();
		r = nextRandom();
		case (r % 32'd20)
			0: return encodeRtype(rs, rt, rd, 5'd0, `FN_ADDU);
			1: return encodeRtype(rs, rt, rd, 5'd0, `FN_SUBU);
			2: return encodeRtype(rs, rt, rd, 5'd0, `FN_AND);
			3: return encodeRtype(rs, rt, rd, 5'd0, `FN_OR);
			4: return encodeRtype(rs, rt, rd, 5'd0, `FN_XOR);
			5: return encodeRtype(rs, rt, rd, 5'd0, `FN_NOR);
			6: return encodeRtype(rs, rt, rd, 5'd0, `FN_SLT);
			7: return encodeRtype(rs, rt, rd, 5'd0, `FN_SLTU);
			8: return encodeRtype(5'd0, rt, rd, r[20:16], `FN_SLL);
			9: return encodeRtype(5'd0, rt, rd, r[20:16], `FN_SRL);
			10: return encodeItype(`OP_ADDIU, rs, rt, r[15:0]);
			11: return encodeItype(`OP_SLTI, rs, rt, r[15:0]);
			12: return encodeItype(`OP_ANDI, rs, rt, r[15:0]);
			13: return encodeItype(`OP_ORI, rs, rt, r[15:0]);
			14: return encodeItype(`OP_XORI, rs, rt, r[15:0]);
			15: return encodeItype(`OP_LUI, 5'd0, rt, r[15:0]);
			// unsupported lw, add and jr encodings
			16: return encodeItype(6'h23, rs, rt, r[15:0]);
			17: return encodeRtype(rs, rt, rd, 5'd0, 6'h20);
			18: return encodeRtype(rs, 5'd0, 5'd0, 5'd0, 6'h08);
			default: return encodeRtype(rs, rt, rd, 5'd0, `FN_SLTU);
		endcase
	endfunction

	// instruction-set reference that queues the expected outcome
	task automatic applyModel(input logic [31:0] word, input int wbEdge);
		logic [4:0] dest;
		logic [15:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] value;
		logic legal;
		imm = word[15:0];
		a = modelRegs[word[25:21]];
		b = modelRegs[word[20:16]];
		se = {{16{imm[15]}}, imm};
		legal = 1'b1;
		dest = word[20:16];
		value = '0;
		case (word[31:26])
			`OP_RTYPE: begin
				dest = word[15:11];
				case (word[5:0])
					`FN_ADDU: value = a + b;
					`FN_SUBU: value = a - b;
					`FN_AND: value = a & b;
					`FN_OR: value = a | b;
					`FN_XOR: value = a ^ b;
					`FN_NOR: value = ~(a | b);
					`FN_SLT: value = {31'b0, $signed(a) < $signed(b)};
					`FN_SLTU: value = {31'b0, a < b};
					`FN_SLL: value = b << word[10:6];
					`FN_SRL: value = b >> word[10:6];
					default: legal = 1'b0;
				endcase
			end
			`OP_ADDIU: value = a + se;
			`OP_SLTI: value = {31'b0, $signed(a) < $signed(se)};
			// logical immediates are zero extended
			`OP_ANDI: value = a & {16'b0, imm};
			`OP_ORI: value = a | {16'b0, imm};
			`OP_XORI: value = a ^ {16'b0, imm};
			`OP_LUI: value = {imm, 16'b0};
			default: legal = 1'b0;
		endcase
		if (legal) begin
			wbEdgeQ.push_back(wbEdge);
			wbExpQ.push_back({dest, value});
			// r0 is reported but keeps reading zero
			if (dest != 5'd0) begin
				modelRegs[dest] = value;
			end
		end else begin
			illEdgeQ.push_back(wbEdge - 1);
		end
	endtask

	// sampled at the next edge and written back two edges after that
	task automatic issueInstr(input logic [31:0] word);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= word;
		applyModel(word, edgeCount + 3);
	endtask

	task automatic idleCycle();
		@(posedge clk);
		instrValid <= 1'b0;
		instr <= nextRandom();
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			expectIll = (illEdgeQ.size() > 0) && (illEdgeQ[0] == edgeCount);
			checkValue({31'b0, illegalInstr}, {31'b0, expectIll}, "illegalInstr");
			if (expectIll) begin
				void'(illEdgeQ.pop_front());
			end
			expectWb = (wbEdgeQ.size() > 0) && (wbEdgeQ[0] == edgeCount);
			checkValue({31'b0, wbValid}, {31'b0, expectWb}, "wbValid");
			if (expectWb) begin
				checkValue({27'b0, wbReg}, {27'b0, wbExpQ[0][36:32]}, "wbReg");
				checkValue(wbData, wbExpQ[0][31:0], "wbData");
				void'(wbEdgeQ.pop_front());
				void'(wbExpQ.pop_front());
			end
		end
	end

	initial begin
		int issued;
		int waitCount;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		rngState = 32'h39cb_8e2b;
		issued = 0;
		waitCount = 0;
		for (int k = 0; k < 32; k++) begin
			modelRegs[k] = '0;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// every register reads zero out of reset
		for (int k = 1; k < 32; k++) begin
			issueInstr(encodeRtype(5'(k), 5'(k), 5'(k), 5'd0, `FN_OR));
		end
		// write to r0 then read it straight back
		issueInstr(encodeItype(`OP_ADDIU, 5'd0, 5'd0, 16'h8001));
		issueInstr(encodeRtype(5'd0, 5'd0, 5'd3, 5'd0, `FN_OR));
		// random mix with roughly one idle cycle in four
		while (issued < 2000) begin
			if (nextRandom() % 32'd4 == 32'd0) begin
				idleCycle();
			end else begin
				issueInstr(randomInstr());
				issued++;
			end
		end
		idleCycle();
		while ((wbEdgeQ.size() > 0 || illEdgeQ.size() > 0) && waitCount < 20) begin
			@(posedge clk);
			waitCount++;
		end
		if (wbEdgeQ.size() > 0 || illEdgeQ.size() > 0) begin
			$display("Timeout: expected writebacks or illegal pulses never appeared");
			$display("Testbench failed");
			$fatal(1, "drain timed out");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/cpuPkg.sv
source/regReadIf.sv
source/issueIf.sv
source/instrDecoder.sv
source/regFile.sv
source/aluExecute.sv
source/execCore.sv
testbench/execCore_assertions.sv
testbench/execCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the execCore testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module execCore_tb -o simv

# the simulator exits non-zero on $fatal, so keep its output either way
output=$(./obj_dir/simv 2>&1 || true)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
	exit 0
else
	exit 1
fi
